// File: src/mem_pkg.sv
/*
 * Instruction memory package
 * Address and data widths, boot ROM geometry and the request and
 * response structs between the fetch unit and instruction memory
 */

package mem_pkg;

    localparam int    ADDR_WIDTH      = 32;
    localparam int    DATA_WIDTH      = 32;
    localparam int    ROM_WORDS       = 64;
    localparam int    ROM_INDEX_WIDTH = $clog2(ROM_WORDS);
    localparam string ROM_FILE        = "boot_rom.hex";

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

// File: src/fetch_pkg.sv
/*
 * Fetch package
 * Reset PC, instruction FIFO depth, the redirect request and the
 * (pc, instruction) bundle carried from fetch to dispatch
 */

package fetch_pkg;

    import mem_pkg::*;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC        = '0;
    localparam int                    INSN_FIFO_DEPTH = 8;

    // Redirect from a later stage, target is word aligned
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] insn;
    } fetch_bundle_t;

endpackage

// File: src/insn_fifo.sv
/*
 * Instruction FIFO
 * Circular buffer of fetch bundles between fetch and dispatch.
 * Pointers carry an extra wrap bit to tell full from empty.
 * Flush empties the buffer and wins over write and acknowledge.
 */

`timescale 1ns/10ps

module insn_fifo #(
    parameter int DEPTH = fetch_pkg::INSN_FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_flush,
    input  logic                     i_we,
    input  fetch_pkg::fetch_bundle_t i_data,
    input  logic                     i_ack,
    output fetch_pkg::fetch_bundle_t o_data,
    output logic                     o_valid,
    output logic                     o_full
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    fetch_bundle_t  mem [DEPTH];
    logic [PTR_W:0] wr_ptr_r;
    logic [PTR_W:0] rd_ptr_r;
    logic           push;
    logic           pop;
    logic           same_index;
    logic           wrap_differs;

    assign same_index   = wr_ptr_r[PTR_W-1:0] == rd_ptr_r[PTR_W-1:0];
    assign wrap_differs = wr_ptr_r[PTR_W] != rd_ptr_r[PTR_W];

    assign o_valid = wr_ptr_r != rd_ptr_r;
    assign o_full  = same_index && wrap_differs;

    // Writes while full are dropped, the producer retries
    assign push = i_we && !o_full;
    assign pop  = i_ack && o_valid;

    assign o_data = mem[rd_ptr_r[PTR_W-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else if (i_flush) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push && !i_flush) begin
            mem[wr_ptr_r[PTR_W-1:0]] <= i_data;
        end
    end

endmodule

// File: src/fetch_unit.sv
/*
 * Fetch unit
 * Selects the next PC, drives the instruction memory request and
 * pushes each returned word, tagged with its pc, into the
 * instruction FIFO. The FIFO head is presented to dispatch.
 */

`timescale 1ns/10ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  fetch_pkg::redirect_t     i_redirect,
    input  mem_pkg::mem_rsp_t        i_mem_rsp,
    output mem_pkg::mem_req_t        o_mem_req,
    input  logic                     i_dispatch_stall,
    output fetch_pkg::fetch_bundle_t o_dispatch,
    output logic                     o_dispatch_valid
);

    import mem_pkg::*;
    import fetch_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_r;
    logic [ADDR_WIDTH-1:0] next_pc;
    logic [ADDR_WIDTH-1:0] data_pc_r;
    logic                  redirect_r;
    logic                  data_valid;
    logic                  fifo_full;
    logic                  fifo_we;
    logic                  dispatch_ack;
    fetch_bundle_t         fifo_wdata;

    // The cycle after a redirect behaves as if data came back
    assign data_valid = i_mem_rsp.valid || redirect_r;

    always_comb begin
        if (i_redirect.valid) begin
            next_pc = i_redirect.target;
        end else if (data_valid && !fifo_full) begin
            next_pc = pc_r + ADDR_WIDTH'(4);
        end else begin
            next_pc = pc_r;
        end
    end

    // Reset counts as a redirect to RESET_PC so the first word is fetched once
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_r       <= RESET_PC;
            redirect_r <= 1'b1;
        end else begin
            pc_r       <= next_pc;
            redirect_r <= i_redirect.valid;
        end
    end

    // pc of the word that memory returns next cycle
    always_ff @(posedge clk) begin
        if (!fifo_full) begin
            data_pc_r <= pc_r;
        end
    end

    // On back-pressure, re-request the word whose write was refused
    always_comb begin
        o_mem_req.en   = !i_redirect.valid;
        o_mem_req.addr = (fifo_full || !data_valid) ? data_pc_r : pc_r;
    end

    assign fifo_we         = i_mem_rsp.valid && !fifo_full;
    assign fifo_wdata.pc   = data_pc_r;
    assign fifo_wdata.insn = i_mem_rsp.data;
    assign dispatch_ack    = !i_dispatch_stall;

    insn_fifo #(
        .DEPTH(INSN_FIFO_DEPTH)
    ) u_insn_fifo (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_flush (i_redirect.valid),
        .i_we    (fifo_we),
        .i_data  (fifo_wdata),
        .i_ack   (dispatch_ack),
        .o_data  (o_dispatch),
        .o_valid (o_dispatch_valid),
        .o_full  (fifo_full)
    );

endmodule

// File: src/boot_rom.sv
/*
 * Boot ROM
 * Word-indexed instruction memory filled from a hex image.
 * Read data and valid are registered, one cycle after the request.
 */

`timescale 1ns/10ps

module boot_rom (
    input  logic              clk,
    input  logic              i_arst_n,
    input  mem_pkg::mem_req_t i_req,
    output mem_pkg::mem_rsp_t o_rsp
);

    import mem_pkg::*;

    logic [DATA_WIDTH-1:0]      rom [ROM_WORDS];
    logic [ROM_INDEX_WIDTH-1:0] index;
    logic [DATA_WIDTH-1:0]      data_r;
    logic                       valid_r;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    // Byte address to word index, upper bits alias
    assign index = i_req.addr[ROM_INDEX_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (i_req.en) begin
            data_r <= rom[index];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= i_req.en;
        end
    end

    assign o_rsp = '{valid: valid_r, data: data_r};

endmodule

// File: src/fetch_top.sv
/*
 * Fetch front end top level
 * Joins the fetch unit to the boot ROM and exposes the redirect
 * input and the dispatch handshake
 */

`timescale 1ns/10ps

module fetch_top (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  fetch_pkg::redirect_t     i_redirect,
    input  logic                     i_dispatch_stall,
    output fetch_pkg::fetch_bundle_t o_dispatch,
    output logic                     o_dispatch_valid
);

    import mem_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    fetch_unit u_fetch_unit (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_redirect      (i_redirect),
        .i_mem_rsp       (mem_rsp),
        .o_mem_req       (mem_req),
        .i_dispatch_stall(i_dispatch_stall),
        .o_dispatch      (o_dispatch),
        .o_dispatch_valid(o_dispatch_valid)
    );

    boot_rom u_boot_rom (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

endmodule

// File: test/fetch_assertions.sv
/*
 * Fetch unit assertions
 * FIFO writes, memory enable around redirects, reset state
 * and the dispatch head holding while stalled
 */

`timescale 1ns/10ps

module fetch_assertions (
    input logic                     clk,
    input logic                     i_arst_n,
    input fetch_pkg::redirect_t     i_redirect,
    input mem_pkg::mem_rsp_t        i_mem_rsp,
    input logic                     i_fifo_full,
    input logic                     i_dispatch_stall,
    input fetch_pkg::fetch_bundle_t i_dispatch,
    input logic                     i_dispatch_valid
);

    // A write taken while full would move the write pointer off the full state
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_fifo_full && i_dispatch_stall && !i_redirect.valid |=> i_fifo_full
    ) else $error("FIFO written while full");

    // No request in a redirect cycle means no response in the next one
    no_fetch_on_redirect: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_redirect.valid |=> !i_mem_rsp.valid
    ) else $error("Memory enabled in a redirect cycle");

    // Sampled mid-cycle so the first check follows the first reset edge
    idle_in_reset: assert property (
        @(negedge clk) !i_arst_n |-> !i_dispatch_valid
    ) else $error("Dispatch valid during reset");

    head_holds_on_stall: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_dispatch_valid && i_dispatch_stall && !i_redirect.valid
        |=> i_dispatch_valid && $stable(i_dispatch)
    ) else $error("Dispatch head changed while stalled");

endmodule

bind fetch_unit fetch_assertions u_fetch_assertions (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_redirect      (i_redirect),
    .i_mem_rsp       (i_mem_rsp),
    .i_fifo_full     (fifo_full),
    .i_dispatch_stall(i_dispatch_stall),
    .i_dispatch      (o_dispatch),
    .i_dispatch_valid(o_dispatch_valid)
);

// File: test/fetch_tb.sv
/*
 * Fetch front end testbench
 * Directed tests on fetch_top against a ROM reference model:
 * reset, unstalled and randomly stalled streams, a full FIFO and
 * redirects inside and above the ROM range. Ends with a summary.
 */

`timescale 1ns/10ps

module fetch_tb;

    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;

    // Cycle budget of each test
    localparam int RESET_STREAM_CYCLES = RESET_CYCLES + 80;
    localparam int RANDOM_STALL_CYCLES = 240;
    localparam int FULL_FIFO_CYCLES    = 90;
    localparam int REDIRECT_CYCLES     = 140;
    localparam int ALIAS_CYCLES        = 80;
    localparam int TOTAL_CYCLES        = RESET_STREAM_CYCLES + RANDOM_STALL_CYCLES
                                       + FULL_FIFO_CYCLES + REDIRECT_CYCLES + ALIAS_CYCLES;

    localparam redirect_t NO_REDIRECT = '{valid: 1'b0, target: '0};

    logic          clk;
    logic          arst_n;
    redirect_t     redirect;
    logic          dispatch_stall;
    fetch_bundle_t dispatch;
    logic          dispatch_valid;

    logic [DATA_WIDTH-1:0] rom_model [ROM_WORDS];
    logic [ADDR_WIDTH-1:0] exp_pc;
    integer                seed = 32'h1666870b;
    int                    errors;
    int                    checks;
    int                    tests_run;
    int                    accepted;

    fetch_top u_dut (
        .clk             (clk),
        .i_arst_n        (arst_n),
        .i_redirect      (redirect),
        .i_dispatch_stall(dispatch_stall),
        .o_dispatch      (dispatch),
        .o_dispatch_valid(dispatch_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("The run timed out after %0d clock periods", TOTAL_CYCLES * 2);
        $display("Finished with errors");
        $finish;
    end

    task automatic compare_bundle(input fetch_bundle_t actual, input fetch_bundle_t expected,
                                  input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s, got pc %h insn %h, expected pc %h insn %h",
                     $time, what, actual.pc, actual.insn, expected.pc, expected.insn);
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s, got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Word the ROM holds for a pc, upper address bits alias
    function automatic fetch_bundle_t expected_bundle(input logic [ADDR_WIDTH-1:0] pc);
        fetch_bundle_t bundle;
        bundle.pc   = pc;
        bundle.insn = rom_model[pc[ROM_INDEX_WIDTH+1:2]];
        return bundle;
    endfunction

    // Drive on the rising edge, look at dispatch on the falling edge
    task automatic drive_cycle(input logic stall, input redirect_t redir);
        @(posedge clk);
        dispatch_stall <= stall;
        redirect       <= redir;
        @(negedge clk);
        if (redirect.valid) begin
            exp_pc = redirect.target;
        end else if (dispatch_valid && !dispatch_stall) begin
            compare_bundle(dispatch, expected_bundle(exp_pc), "dispatched bundle");
            exp_pc = exp_pc + ADDR_WIDTH'(4);
            accepted++;
        end
    endtask

    task automatic receive_bundles(input int count, input logic random_stall);
        logic [31:0] rnd;
        logic        stall;
        accepted = 0;
        while (accepted < count) begin
            stall = 1'b0;
            if (random_stall) begin
                rnd   = $random(seed);
                stall = rnd[0];
            end
            drive_cycle(stall, NO_REDIRECT);
        end
    endtask

    task automatic hold_stall(input int cycles);
        repeat (cycles) begin
            drive_cycle(1'b1, NO_REDIRECT);
        end
    endtask

    task automatic send_redirect(input logic [ADDR_WIDTH-1:0] target, input logic stall);
        redirect_t redir;
        redir.valid  = 1'b1;
        redir.target = target;
        drive_cycle(stall, redir);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        $display("Test %0d %s: %s", tests_run, name,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    task automatic test_reset_stream();
        int errors_before;
        errors_before = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_bit(dispatch_valid, 1'b0, "dispatch valid during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        exp_pc = RESET_PC;
        receive_bundles(40, 1'b0);
        end_test("reset and unstalled stream", errors_before);
    endtask

    task automatic test_random_stall();
        int errors_before;
        errors_before = errors;
        receive_bundles(60, 1'b1);
        end_test("random stall stream", errors_before);
    endtask

    task automatic test_full_fifo();
        int errors_before;
        errors_before = errors;
        hold_stall(30);
        compare_bit(dispatch_valid, 1'b1, "dispatch valid after long stall");
        receive_bundles(20, 1'b0);
        end_test("full FIFO and release", errors_before);
    endtask

    task automatic test_redirect();
        int errors_before;
        errors_before = errors;
        send_redirect(32'h0000_0040, 1'b0);
        receive_bundles(12, 1'b0);
        // Redirect again while the FIFO is full
        hold_stall(30);
        send_redirect(32'h0000_0084, 1'b1);
        hold_stall(5);
        receive_bundles(12, 1'b1);
        end_test("redirect inside ROM", errors_before);
    endtask

    task automatic test_alias();
        int errors_before;
        errors_before = errors;
        send_redirect(32'h1000_00f0, 1'b0);
        receive_bundles(16, 1'b1);
        end_test("redirect above ROM range", errors_before);
    endtask

    initial begin
        arst_n         = 1'b0;
        redirect       = NO_REDIRECT;
        dispatch_stall = 1'b0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        accepted       = 0;
        exp_pc         = RESET_PC;
        $readmemh(ROM_FILE, rom_model);

        test_reset_stream();
        test_random_stall();
        test_full_fifo();
        test_redirect();
        test_alias();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: boot_rom.hex
// Boot ROM image, one 32-bit word per line in hex, word index 0 to 63
// Word n encodes addi x1, x0, n
00000093
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00a00093
00b00093
00c00093
00d00093
00e00093
00f00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01a00093
01b00093
01c00093
01d00093
01e00093
01f00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02a00093
02b00093
02c00093
02d00093
02e00093
02f00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03a00093
03b00093
03c00093
03d00093
03e00093
03f00093

// File: filelist.f
src/mem_pkg.sv
src/fetch_pkg.sv
src/insn_fifo.sv
src/fetch_unit.sv
src/boot_rom.sv
src/fetch_top.sv
test/fetch_assertions.sv
test/fetch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
